// ==== all.f ====
common/dz_pkg.sv
logic/pic_sequencer.sv
dz/dz_pic_decode.sv
dz/dz_glyph_rom.sv
dz/dz_show.sv
logic/dz_top.sv
dv/dz_clk_gen.sv
dv/dz_chk.sv
dv/dz_tb.sv

// ==== Makefile ====
SRCS := $(shell cat all.f)

obj_dir/Vdz_tb: all.f $(SRCS)
	verilator --binary --timing --assert --top-module dz_tb -f all.f -o Vdz_tb

run: obj_dir/Vdz_tb
	./obj_dir/Vdz_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== dv/dz_tb.sv ====
`timescale 1ns/10ps

module dz_tb
    import dz_pkg::*;
;

    typedef struct packed {
        pic_t pic_sel;
        logic temp;
        logic st;
        logic auto_en;
    } stim_t;

    localparam int SETTLE       = 2;    // capture starts on the third edge
    localparam int MODE_SETTLE  = 3;    // a sequencer state change costs one more edge
    localparam int ANIM_TIMEOUT = 600;

    logic        clk;
    logic        rst;
    logic        auto_en;
    pic_t        pic_sel;
    logic        temp;
    logic        st;
    row_bits_t   row;
    row_bits_t   colg;
    row_bits_t   colr;
    stim_t       stim_q[$];
    int unsigned rnd_state;

    dz_clk_gen i_clk_gen (.clk(clk), .rst(rst));

    dz_top #(.FRAME_CYCLES(40)) i_dut (
        .clk     (clk),
        .rst     (rst),
        .auto_en (auto_en),
        .pic_sel (pic_sel),
        .temp    (temp),
        .st      (st),
        .row     (row),
        .colg    (colg),
        .colr    (colr)
    );

    bind dz_show dz_chk i_chk (.clk(clk), .rst(rst), .row(row), .colg(colg), .colr(colr));

    task automatic report_fail();
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        report_fail();
    endtask

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // golden pictures with row 7 in the top byte
    function automatic row_bits_t gold_green(input pic_t p, input row_idx_t r);
        logic [63:0] w;
        case (p)
            4'd0:    w = 64'h0000_183C_3C18_0000;
            4'd1:    w = 64'h0000_387C_7C38_0000;
            4'd2:    w = 64'h0000_3C7E_7E3C_0000;
            4'd3:    w = 64'h003C_7E7E_7E7E_3C00;
            4'd4:    w = 64'h3C7E_FFFF_FFFF_7E3C;
            4'd5:    w = 64'hFFFF_FFFF_FFFF_FFFF;
            4'd6:    w = 64'hFBF7_E7C7_E3F1_E3C3;
            4'd7:    w = 64'hF3E7_C783_C381_0100;
            4'd9:    w = 64'h001C_3E3F_FC60_0000;
            4'd10:   w = 64'h0024_7E7E_3C18_0000;
            default: w = '0;
        endcase
        return w[r*8 +: 8];
    endfunction

    function automatic row_bits_t gold_own_red(input pic_t p, input row_idx_t r);
        logic [63:0] w;
        case (p)
            4'd8:    w = 64'h38C4_324A_5A44_3800;
            4'd11:   w = 64'h1C3E_3331_30E0_60E0;
            default: w = '0;
        endcase
        return w[r*8 +: 8];
    endfunction

    function automatic row_bits_t gold_red(input pic_t p, input logic tmp, input row_idx_t r);
        if (p == 4'd8 || p == 4'd11)
            return gold_own_red(p, r);
        if (p == 4'd6 || p == 4'd7 || p == 4'd9 || (tmp && p <= 4'd5))
            return gold_green(p, r);    // yellow
        return '0;
    endfunction

    function automatic bit is_one_cold(input row_bits_t r);
        return $countones(~r) == 1;
    endfunction

    function automatic row_idx_t cold_index(input row_bits_t r);
        row_idx_t idx;
        idx = '0;
        for (int i = 0; i < 8; i++)
            if (!r[i])
                idx = row_idx_t'(i);
        return idx;
    endfunction

    function automatic stim_t make_stim(input pic_t p, input logic tmp, input logic s,
                                        input logic en);
        stim_t v;
        v.pic_sel = p;
        v.temp    = tmp;
        v.st      = s;
        v.auto_en = en;
        return v;
    endfunction

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++)
            @(posedge clk);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst)
        begin
            if (n >= 20)
            begin
                $display("reset was never released");
                report_fail();
            end
            else
            begin
                @(posedge clk);
                n++;
            end
        end
    endtask

    task automatic apply_stim(input stim_t s);
        @(posedge clk);
        #1;
        pic_sel = s.pic_sel;
        temp    = s.temp;
        st      = s.st;
        auto_en = s.auto_en;
    endtask

    // one sampled cycle against the golden picture
    task automatic check_row(input pic_t p, input logic tmp, input logic on);
        row_idx_t idx;
        if (!on)
        begin
            assert (row == '1 && colg == '0 && colr == '0)
            else mismatch($sformatf("dark expected, row %h colg %h colr %h", row, colg, colr));
        end
        else
        begin
            assert (is_one_cold(row))
            else mismatch($sformatf("row %h is not one-cold", row));
            idx = cold_index(row);
            assert (colg == gold_green(p, idx))
            else mismatch($sformatf("pic %0d row %0d colg %h expected %h",
                                    p, idx, colg, gold_green(p, idx)));
            assert (colr == gold_red(p, tmp, idx))
            else mismatch($sformatf("pic %0d temp %0b row %0d colr %h expected %h",
                                    p, tmp, idx, colr, gold_red(p, tmp, idx)));
        end
    endtask

    task automatic check_scan(input stim_t s);
        for (int c = 0; c < 8; c++)
        begin
            @(posedge clk);
            #2;
            check_row(s.pic_sel, s.temp, s.st);
        end
    endtask

    task automatic build_table();
        pic_t p;
        for (int i = 0; i < 16; i++)
            stim_q.push_back(make_stim(pic_t'(i), 1'b0, 1'b1, 1'b0));
        for (int i = 0; i < 16; i++)
            stim_q.push_back(make_stim(pic_t'(i), 1'b1, 1'b1, 1'b0));
        stim_q.push_back(make_stim(4'd8, 1'b1, 1'b0, 1'b0));   // blanked again
        stim_q.push_back(make_stim(4'd8, 1'b1, 1'b1, 1'b0));
        for (int i = 0; i < 12; i++)
        begin
            rnd_state = lcg_next(rnd_state);
            p = pic_t'(rnd_state >> 16);
            stim_q.push_back(make_stim(p, rnd_state[23], 1'b1, 1'b0));
        end
    endtask

    // frames must match 0..5 in non-decreasing order until the hold picture
    task automatic run_animation();
        pic_t     cur;
        row_idx_t idx;
        bit       found;
        int       waited;
        cur    = PIC_GROW_FIRST;
        waited = 0;
        apply_stim(make_stim(4'd12, 1'b1, 1'b1, 1'b1));
        wait_cycles(MODE_SETTLE);
        while (cur != PIC_HOLD)
        begin
            if (waited >= ANIM_TIMEOUT)
            begin
                $display("animation did not reach the hold picture in time");
                report_fail();
            end
            else
            begin
                @(posedge clk);
                #2;
                assert (is_one_cold(row))
                else mismatch($sformatf("row %h is not one-cold during animation", row));
                idx   = cold_index(row);
                found = 1'b0;
                for (int k = int'(cur); k <= int'(PIC_HOLD) && !found; k++)
                begin
                    if (colg == gold_green(pic_t'(k), idx) &&
                        colr == gold_red(pic_t'(k), 1'b1, idx))
                    begin
                        found = 1'b1;
                        cur   = pic_t'(k);
                    end
                end
                assert (found)
                else mismatch($sformatf("row %0d colg %h fits no frame from %0d on",
                                        idx, colg, cur));
                waited++;
            end
        end
        check_scan(make_stim(PIC_HOLD, 1'b1, 1'b1, 1'b1));
    endtask

    initial
    begin
        for (int i = 0; i < 100; i++)
            #1000;
        $display("simulation did not finish within its time limit");
        report_fail();
    end

    initial
    begin
        auto_en   = 1'b0;
        pic_sel   = '0;
        temp      = 1'b0;
        st        = 1'b0;
        rnd_state = 238;
        @(posedge clk);
        #2;
        check_row(4'd0, 1'b0, 1'b0);    // outputs while reset is held
        wait_reset_release();
        check_scan(make_stim(4'd0, 1'b0, 1'b0, 1'b0));    // still dark after reset
        build_table();
        foreach (stim_q[i])
        begin
            apply_stim(stim_q[i]);
            wait_cycles(SETTLE);
            check_scan(stim_q[i]);
        end
        run_animation();
        apply_stim(make_stim(4'd9, 1'b1, 1'b1, 1'b0));      // back to manual
        wait_cycles(MODE_SETTLE);
        check_scan(make_stim(4'd9, 1'b1, 1'b1, 1'b0));
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== dv/dz_chk.sv ====
`timescale 1ns/10ps

module dz_chk
    import dz_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input row_bits_t row,
    input row_bits_t colg,
    input row_bits_t colr
);

    // either dark or exactly one active-low row
    a_row_shape: assert property (@(posedge clk) disable iff (rst)
        row == '1 || $countones(~row) == 1)
        else $error("row output drives more than one row");

    a_dark_cols: assert property (@(posedge clk) disable iff (rst)
        row == '1 |-> (colg == '0 && colr == '0))
        else $error("column outputs active while no row is driven");

    // consecutive scanned rows step by one, 7 wraps to 0
    a_row_step: assert property (@(posedge clk) disable iff (rst)
        (row != '1 && $past(row) != '1) |-> row == {$past(row[6:0]), $past(row[7])})
        else $error("scanned row did not advance by one");

endmodule

// ==== dv/dz_clk_gen.sv ====
`timescale 1ns/10ps

module dz_clk_gen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES  = 4
)(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;   // 10 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;  // release away from the edge
    end

endmodule

// ==== logic/dz_top.sv ====
`timescale 1ns/10ps

module dz_top
    import dz_pkg::*;
#(
    parameter int FRAME_CYCLES = 1000
)(
    input  logic      clk,
    input  logic      rst,
    input  logic      auto_en,
    input  pic_t      pic_sel,
    input  logic      temp,
    input  logic      st,
    output row_bits_t row,
    output row_bits_t colg,
    output row_bits_t colr
);

    pic_t    pic_code;
    dz_cmd_t cmd;
    logic    blank;

    pic_sequencer #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) i_seq (
        .clk      (clk),
        .rst      (rst),
        .auto_en  (auto_en),
        .pic_sel  (pic_sel),
        .pic_code (pic_code)
    );

    dz_pic_decode i_decode (
        .clk      (clk),
        .rst      (rst),
        .pic_code (pic_code),
        .temp     (temp),
        .st       (st),
        .cmd      (cmd),
        .blank    (blank)
    );

    dz_show i_show (
        .clk   (clk),
        .rst   (rst),
        .cmd   (cmd),
        .blank (blank),
        .row   (row),
        .colg  (colg),
        .colr  (colr)
    );

endmodule

// ==== dz/dz_show.sv ====
`timescale 1ns/10ps

module dz_show
    import dz_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  dz_cmd_t   cmd,
    input  logic      blank,
    output row_bits_t row,
    output row_bits_t colg,
    output row_bits_t colr
);

    row_idx_t   row_idx;
    glyph_row_t glyph;
    row_bits_t  red_row;

    dz_glyph_rom i_rom (
        .pic     (cmd.pic),
        .row_idx (row_idx),
        .glyph   (glyph)
    );

    // scan counter, parked on row 0 while blanked
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (blank)
            row_idx <= '0;
        else
            row_idx <= row_idx + 3'd1;  // wraps 7 -> 0
    end

    always_comb
    begin
        case (cmd.red_src)
            red_copy: red_row = glyph.green;
            red_own:  red_row = glyph.red;
            default:  red_row = '0;
        endcase
    end

    // row and columns taken from the same row_idx, so they stay aligned
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colg <= '0;
            colr <= '0;
        end
        else if (blank)
        begin
            row  <= '1;
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= ~(row_bits_t'(1) << row_idx);   // active low row
            colg <= glyph.green;
            colr <= red_row;
        end
    end

endmodule

// ==== dz/dz_glyph_rom.sv ====
`timescale 1ns/10ps

module dz_glyph_rom
    import dz_pkg::*;
(
    input  pic_t       pic,
    input  row_idx_t   row_idx,
    output glyph_row_t glyph
);

    always_comb
    begin
        glyph = '0;
        case (pic)
            4'd0:
                case (row_idx)
                    3'd2, 3'd5: glyph.green = 8'b0001_1000;
                    3'd3, 3'd4: glyph.green = 8'b0011_1100;
                    default:    glyph.green = 8'b0000_0000;
                endcase
            4'd1:
                case (row_idx)
                    3'd2, 3'd5: glyph.green = 8'b0011_1000;
                    3'd3, 3'd4: glyph.green = 8'b0111_1100;
                    default:    glyph.green = 8'b0000_0000;
                endcase
            4'd2:
                case (row_idx)
                    3'd2, 3'd5: glyph.green = 8'b0011_1100;
                    3'd3, 3'd4: glyph.green = 8'b0111_1110;
                    default:    glyph.green = 8'b0000_0000;
                endcase
            4'd3:
                case (row_idx)
                    3'd1, 3'd6:             glyph.green = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: glyph.green = 8'b0111_1110;
                    default:                glyph.green = 8'b0000_0000;
                endcase
            4'd4:
                case (row_idx)
                    3'd0, 3'd7: glyph.green = 8'b0011_1100;
                    3'd1, 3'd6: glyph.green = 8'b0111_1110;
                    default:    glyph.green = 8'b1111_1111;
                endcase
            4'd5: glyph.green = 8'b1111_1111;     // full frame, end of growth
            4'd6:
                case (row_idx)
                    3'd0: glyph.green = 8'b1100_0011;
                    3'd1: glyph.green = 8'b1110_0011;
                    3'd2: glyph.green = 8'b1111_0001;
                    3'd3: glyph.green = 8'b1110_0011;
                    3'd4: glyph.green = 8'b1100_0111;
                    3'd5: glyph.green = 8'b1110_0111;
                    3'd6: glyph.green = 8'b1111_0111;
                    3'd7: glyph.green = 8'b1111_1011;
                endcase
            4'd7:
                case (row_idx)
                    3'd1:    glyph.green = 8'b0000_0001;
                    3'd2:    glyph.green = 8'b1000_0001;
                    3'd3:    glyph.green = 8'b1100_0011;
                    3'd4:    glyph.green = 8'b1000_0011;
                    3'd5:    glyph.green = 8'b1100_0111;
                    3'd6:    glyph.green = 8'b1110_0111;
                    3'd7:    glyph.green = 8'b1111_0011;
                    default: glyph.green = 8'b0000_0000;
                endcase
            4'd8:   // red only
                case (row_idx)
                    3'd1:    glyph.red = 8'b0011_1000;
                    3'd2:    glyph.red = 8'b0100_0100;
                    3'd3:    glyph.red = 8'b0101_1010;
                    3'd4:    glyph.red = 8'b0100_1010;
                    3'd5:    glyph.red = 8'b0011_0010;
                    3'd6:    glyph.red = 8'b1100_0100;
                    3'd7:    glyph.red = 8'b0011_1000;
                    default: glyph.red = 8'b0000_0000;
                endcase
            4'd9:
                case (row_idx)
                    3'd2:    glyph.green = 8'b0110_0000;
                    3'd3:    glyph.green = 8'b1111_1100;
                    3'd4:    glyph.green = 8'b0011_1111;
                    3'd5:    glyph.green = 8'b0011_1110;
                    3'd6:    glyph.green = 8'b0001_1100;
                    default: glyph.green = 8'b0000_0000;
                endcase
            4'd10:
                case (row_idx)
                    3'd2:       glyph.green = 8'b0001_1000;
                    3'd3:       glyph.green = 8'b0011_1100;
                    3'd4, 3'd5: glyph.green = 8'b0111_1110;
                    3'd6:       glyph.green = 8'b0010_0100;
                    default:    glyph.green = 8'b0000_0000;
                endcase
            4'd11:
                case (row_idx)
                    3'd0: glyph.red = 8'b1110_0000;
                    3'd1: glyph.red = 8'b0110_0000;
                    3'd2: glyph.red = 8'b1110_0000;
                    3'd3: glyph.red = 8'b0011_0000;
                    3'd4: glyph.red = 8'b0011_0001;
                    3'd5: glyph.red = 8'b0011_0011;
                    3'd6: glyph.red = 8'b0011_1110;
                    3'd7: glyph.red = 8'b0001_1100;
                endcase
            default: glyph = '0;    // 12..15 dark
        endcase
    end

endmodule

// ==== dz/dz_pic_decode.sv ====
`timescale 1ns/10ps

module dz_pic_decode
    import dz_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  pic_t    pic_code,
    input  logic    temp,
    input  logic    st,
    output dz_cmd_t cmd,
    output logic    blank
);

    red_src_t red_next;

    // colour rule
    always_comb
    begin
        case (pic_code)
            4'd8, 4'd11:                      red_next = red_own;
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: red_next = temp ? red_copy : red_off;
            4'd6, 4'd7, 4'd9:                 red_next = red_copy;   // always yellow
            default:                          red_next = red_off;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cmd.pic     <= '0;
            cmd.red_src <= red_off;
            blank       <= 1'b1;    // dark until st comes up
        end
        else
        begin
            cmd.pic     <= pic_code;
            cmd.red_src <= red_next;
            blank       <= ~st;
        end
    end

endmodule

// ==== logic/pic_sequencer.sv ====
`timescale 1ns/10ps

module pic_sequencer
    import dz_pkg::*;
#(
    parameter int FRAME_CYCLES = 1000
)(
    input  logic clk,
    input  logic rst,
    input  logic auto_en,
    input  pic_t pic_sel,
    output pic_t pic_code
);

    localparam int CNT_W = $clog2(FRAME_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FRAME_CYCLES - 1);

    seq_state_t       state;
    pic_t             frame;
    logic [CNT_W-1:0] frame_cnt;
    logic             auto_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= seq_manual;
            frame     <= PIC_GROW_FIRST;
            frame_cnt <= '0;
            auto_q    <= 1'b0;
            pic_code  <= '0;
        end
        else
        begin
            auto_q <= auto_en;

            // output follows state and frame one edge later
            case (state)
                seq_grow: pic_code <= frame;
                seq_hold: pic_code <= PIC_HOLD;
                default:  pic_code <= pic_sel;
            endcase

            case (state)
                seq_manual:
                begin
                    if (auto_en && !auto_q)     // rising edge only
                    begin
                        state     <= seq_grow;
                        frame     <= PIC_GROW_FIRST;
                        frame_cnt <= '0;
                    end
                end
                seq_grow:
                begin
                    if (!auto_en)
                        state <= seq_manual;
                    else if (frame_cnt == CNT_LAST)
                    begin
                        frame_cnt <= '0;
                        if (frame == PIC_GROW_LAST)
                            state <= seq_hold;
                        else
                            frame <= frame + 4'd1;
                    end
                    else
                        frame_cnt <= frame_cnt + 1'b1;
                end
                seq_hold:
                begin
                    if (!auto_en)
                        state <= seq_manual;
                end
                default: state <= seq_manual;
            endcase
        end
    end

endmodule

// ==== common/dz_pkg.sv ====
package dz_pkg;

    // one row of the matrix, bit i is column i (or row i on the row port)
    typedef logic [7:0] row_bits_t;

    // scanned row index
    typedef logic [2:0] row_idx_t;

    // picture code, 0..15
    typedef logic [3:0] pic_t;

    // where the red plane comes from
    typedef enum logic [1:0] {
        red_off,
        red_copy,   // red mirrors green, shows yellow
        red_own
    } red_src_t;

    typedef struct packed {
        pic_t     pic;
        red_src_t red_src;
    } dz_cmd_t;

    typedef struct packed {
        row_bits_t green;
        row_bits_t red;
    } glyph_row_t;

    typedef enum logic [1:0] {
        seq_manual,
        seq_grow,
        seq_hold
    } seq_state_t;

    // growing animation frames
    localparam pic_t PIC_GROW_FIRST = 4'd0;
    localparam pic_t PIC_GROW_LAST  = 4'd4;
    localparam pic_t PIC_HOLD       = 4'd5;

endpackage
